// File: countdown_core.sv
`timescale 1ns/1ps

module countdown_core
    import timer_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sec_tick,
    input  logic      go,
    input  hms_time_t preset,
    output hms_time_t cur_time,
    output logic      finish
);

    core_state_t state;
    logic        time_zero;

    // one second less, borrowing upward through the digits
    // only called on a nonzero time, so hr_10 never underflows
    function automatic hms_time_t dec_time(input hms_time_t t);
        hms_time_t r;
        r = t;
        if (t.sec_1 != 4'd0) begin
            r.sec_1 = t.sec_1 - 4'd1;
        end else begin
            r.sec_1 = 4'd9;
            if (t.sec_10 != 4'd0) begin
                r.sec_10 = t.sec_10 - 4'd1;
            end else begin
                r.sec_10 = 4'd5;
                if (t.min_1 != 4'd0) begin
                    r.min_1 = t.min_1 - 4'd1;
                end else begin
                    r.min_1 = 4'd9;
                    if (t.min_10 != 4'd0) begin
                        r.min_10 = t.min_10 - 4'd1;
                    end else begin
                        r.min_10 = 4'd5;
                        if (t.hr_1 != 4'd0) begin
                            r.hr_1 = t.hr_1 - 4'd1;
                        end else begin
                            r.hr_1  = 4'd9;
                            r.hr_10 = t.hr_10 - 4'd1;
                        end
                    end
                end
            end
        end
        return r;
    endfunction

    // every digit within its BCD range
    function automatic logic digits_legal(input hms_time_t t);
        logic ok;
        ok = (t.hr_10 <= 4'd9) && (t.hr_1 <= 4'd9) &&
             (t.min_10 <= 4'd5) && (t.min_1 <= 4'd9) &&
             (t.sec_10 <= 4'd5) && (t.sec_1 <= 4'd9);
        return ok;
    endfunction

    assign time_zero = (cur_time == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            cur_time <= '0;
        end else if (!go) begin
            // idle tracks the preset, also the way out of DONE
            state    <= IDLE;
            cur_time <= preset;
        end else begin
            case (state)
                IDLE, RUN: begin
                    if (sec_tick && time_zero) begin
                        state <= DONE;
                    end else begin
                        state <= RUN;
                        if (sec_tick) begin
                            cur_time <= dec_time(cur_time);
                        end
                    end
                end
                DONE: begin
                    // hold at zero until go drops
                    state <= DONE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign finish = (state == DONE);

    a_finish_at_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        finish |-> time_zero
    ) else $error("finish high with nonzero time");

    a_digits_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        digits_legal(cur_time)
    ) else $error("illegal BCD digit in cur_time");

endmodule

// File: countdown_timer.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module countdown_timer
    import timer_pkg::*;
#(
    parameter int unsigned tick_div = `TIMER_TICK_DIV
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic       go,
    input  disp_word_t preset_in,
    output disp_word_t display_word,
    output logic       finish,
    output logic [5:0] digit_sel,
    output logic [6:0] seg
);

    logic      sec_tick;
    hms_time_t preset;
    hms_time_t cur_time;

    tick_gen #(
        .tick_div (tick_div)
    ) u_tick_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .sec_tick (sec_tick)
    );

    preset_latch u_preset_latch (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .preset_in (preset_in),
        .preset    (preset)
    );

    countdown_core u_countdown_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .sec_tick (sec_tick),
        .go       (go),
        .preset   (preset),
        .cur_time (cur_time),
        .finish   (finish)
    );

    display_scan u_display_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .cur_time     (cur_time),
        .display_word (display_word),
        .digit_sel    (digit_sel),
        .seg          (seg)
    );

endmodule

// File: display_scan.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module display_scan
    import timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  hms_time_t  cur_time,
    output disp_word_t display_word,
    output logic [5:0] digit_sel,
    output logic [6:0] seg
);

    localparam int unsigned scan_w = (`TIMER_SCAN_DIV > 1) ? $clog2(`TIMER_SCAN_DIV) : 1;

    logic [scan_w-1:0] scan_cnt;
    logic              scan_wrap;
    logic [2:0]        digit_idx;
    logic [2:0]        next_idx;

    // active low, seg[6] is a and seg[0] is g
    function automatic logic [6:0] seg_decode(input bcd_digit_t d);
        logic [6:0] s;
        case (d)
            4'd0:    s = 7'b0000001;
            4'd1:    s = 7'b1001111;
            4'd2:    s = 7'b0010010;
            4'd3:    s = 7'b0000110;
            4'd4:    s = 7'b1001100;
            4'd5:    s = 7'b0100100;
            4'd6:    s = 7'b0100000;
            4'd7:    s = 7'b0001111;
            4'd8:    s = 7'b0000000;
            4'd9:    s = 7'b0000100;
            default: s = 7'b1111111;
        endcase
        return s;
    endfunction

    // scan order, seconds units first
    function automatic bcd_digit_t pick_digit(input hms_time_t t, input logic [2:0] idx);
        bcd_digit_t d;
        case (idx)
            3'd0:    d = t.sec_1;
            3'd1:    d = t.sec_10;
            3'd2:    d = t.min_1;
            3'd3:    d = t.min_10;
            3'd4:    d = t.hr_1;
            default: d = t.hr_10;
        endcase
        return d;
    endfunction

    assign display_word = {cur_time.hr_10, cur_time.hr_1, `TIMER_BLANK_NIBBLE,
                           cur_time.min_10, cur_time.min_1, `TIMER_BLANK_NIBBLE,
                           cur_time.sec_10, cur_time.sec_1};

    assign scan_wrap = (scan_cnt == scan_w'(`TIMER_SCAN_DIV - 1));

    always_comb begin
        next_idx = digit_idx;
        if (scan_wrap) begin
            next_idx = (digit_idx == 3'(`TIMER_NUM_DIGITS - 1)) ? 3'd0 : digit_idx + 3'd1;
        end
    end

    // seg follows the same index as digit_sel, so both move together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt  <= '0;
            digit_idx <= 3'd0;
            digit_sel <= 6'b000001;
            seg       <= seg_decode(4'd0);
        end else begin
            scan_cnt  <= scan_wrap ? '0 : scan_cnt + 1'b1;
            digit_idx <= next_idx;
            seg       <= seg_decode(pick_digit(cur_time, next_idx));
            if (scan_wrap) begin
                digit_sel <= {digit_sel[4:0], digit_sel[5]};
            end
        end
    end

    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(digit_sel)
    ) else $error("digit_sel not one-hot");

endmodule

// File: preset_latch.sv
`timescale 1ns/1ps

module preset_latch
    import timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  disp_word_t preset_in,
    output hms_time_t  preset
);

    hms_time_t raw;
    hms_time_t clean;

    // units digits saturate at 9
    function automatic bcd_digit_t clamp_units(input bcd_digit_t d);
        bcd_digit_t r;
        r = (d > 4'd9) ? 4'd9 : d;
        return r;
    endfunction

    // tens of minutes and seconds saturate at 5
    function automatic bcd_digit_t clamp_tens(input bcd_digit_t d);
        bcd_digit_t r;
        r = (d > 4'd5) ? 4'd5 : d;
        return r;
    endfunction

    // pull the digits out of the display layout, blanks dropped
    always_comb begin
        raw.hr_10  = preset_in[31:28];
        raw.hr_1   = preset_in[27:24];
        raw.min_10 = preset_in[19:16];
        raw.min_1  = preset_in[15:12];
        raw.sec_10 = preset_in[7:4];
        raw.sec_1  = preset_in[3:0];
    end

    always_comb begin
        clean.hr_10  = clamp_units(raw.hr_10);
        clean.hr_1   = clamp_units(raw.hr_1);
        clean.min_10 = clamp_tens(raw.min_10);
        clean.min_1  = clamp_units(raw.min_1);
        clean.sec_10 = clamp_tens(raw.sec_10);
        clean.sec_1  = clamp_units(raw.sec_1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            preset <= '0;
        end else if (load) begin
            preset <= clean;
        end
    end

    // tens fields must be valid for the countdown borrow
    a_tens_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (preset.min_10 <= 4'd5) && (preset.sec_10 <= 4'd5)
    ) else $error("preset tens digit above 5");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the countdown timer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_countdown_timer -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -qx ">>> PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb_countdown_timer.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module tb_countdown_timer
    import timer_pkg::*;
();

    localparam int tb_tick_div     = 5;
    localparam int clk_period      = 4;
    localparam int num_seqs        = 20;
    localparam int seq_cycles      = 60;
    localparam int finish_wait     = 100;
    // upper bound on the directed tests, finish wait included
    localparam int directed_cycles = 400;
    localparam int margin_cycles   = 200;
    localparam int watchdog_cycles = directed_cycles + num_seqs * seq_cycles + margin_cycles;

    logic       clk;
    logic       rst_n;
    logic       load;
    logic       go;
    disp_word_t preset_in;
    disp_word_t display_word;
    logic       finish;
    logic [5:0] digit_sel;
    logic [6:0] seg;

    // reference model state, as it stands after each edge
    int          cyc;
    logic        m_tick;
    hms_time_t   m_preset;
    hms_time_t   m_cur;
    logic        m_finish;
    logic [2:0]  m_idx;
    logic [6:0]  m_seg;
    int          errors;
    logic [31:0] lcg_state;

    countdown_timer #(
        .tick_div (tb_tick_div)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .go           (go),
        .preset_in    (preset_in),
        .display_word (display_word),
        .finish       (finish),
        .digit_sel    (digit_sel),
        .seg          (seg)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bcd_digit_t limit_digit(input bcd_digit_t d, input bcd_digit_t max);
        return (d > max) ? max : d;
    endfunction

    // blank nibbles at [23:20] and [11:8] carry no data
    function automatic hms_time_t sanitize(input disp_word_t w);
        hms_time_t t;
        t.hr_10  = limit_digit(w[31:28], 4'd9);
        t.hr_1   = limit_digit(w[27:24], 4'd9);
        t.min_10 = limit_digit(w[19:16], 4'd5);
        t.min_1  = limit_digit(w[15:12], 4'd9);
        t.sec_10 = limit_digit(w[7:4], 4'd5);
        t.sec_1  = limit_digit(w[3:0], 4'd9);
        return t;
    endfunction

    function automatic int to_secs(input hms_time_t t);
        int hrs;
        int mins;
        hrs  = int'(t.hr_10) * 10 + int'(t.hr_1);
        mins = int'(t.min_10) * 10 + int'(t.min_1);
        return (hrs * 60 + mins) * 60 + int'(t.sec_10) * 10 + int'(t.sec_1);
    endfunction

    function automatic hms_time_t from_secs(input int s);
        hms_time_t t;
        int hrs;
        int mins;
        hrs      = s / 3600;
        mins     = (s / 60) % 60;
        t.hr_10  = 4'(hrs / 10);
        t.hr_1   = 4'(hrs % 10);
        t.min_10 = 4'(mins / 10);
        t.min_1  = 4'(mins % 10);
        t.sec_10 = 4'((s % 60) / 10);
        t.sec_1  = 4'(s % 10);
        return t;
    endfunction

    function automatic disp_word_t word_of(input hms_time_t t);
        return {t.hr_10, t.hr_1, `TIMER_BLANK_NIBBLE, t.min_10, t.min_1,
                `TIMER_BLANK_NIBBLE, t.sec_10, t.sec_1};
    endfunction

    // scan position 0 is sec_1, 5 is hr_10
    function automatic bcd_digit_t digit_at(input hms_time_t t, input logic [2:0] pos);
        bcd_digit_t d;
        case (pos)
            3'd0:    d = t.sec_1;
            3'd1:    d = t.sec_10;
            3'd2:    d = t.min_1;
            3'd3:    d = t.min_10;
            3'd4:    d = t.hr_1;
            default: d = t.hr_10;
        endcase
        return d;
    endfunction

    function automatic logic [6:0] seg_expect(input bcd_digit_t d);
        logic [6:0] lit;
        // lit segments, a in bit 6 down to g in bit 0
        case (d)
            4'd0:    lit = 7'b1111110;
            4'd1:    lit = 7'b0110000;
            4'd2:    lit = 7'b1101101;
            4'd3:    lit = 7'b1111001;
            4'd4:    lit = 7'b0110011;
            4'd5:    lit = 7'b1011011;
            4'd6:    lit = 7'b1011111;
            4'd7:    lit = 7'b1110000;
            4'd8:    lit = 7'b1111111;
            4'd9:    lit = 7'b1111011;
            default: lit = 7'b0000000;
        endcase
        return ~lit;
    endfunction

    // advance the model by one edge, using the inputs the DUT samples there
    task automatic model_step();
        hms_time_t  nxt_cur;
        logic       nxt_fin;
        logic [2:0] nxt_idx;
        cyc     = cyc + 1;
        nxt_cur = m_cur;
        nxt_fin = m_finish;
        if (!go) begin
            nxt_cur = m_preset;
            nxt_fin = 1'b0;
        end else if (!m_finish && m_tick) begin
            if (to_secs(m_cur) == 0) begin
                nxt_fin = 1'b1;
            end else begin
                nxt_cur = from_secs(to_secs(m_cur) - 1);
            end
        end
        if (load) begin
            m_preset = sanitize(preset_in);
        end
        nxt_idx  = 3'((cyc / `TIMER_SCAN_DIV) % `TIMER_NUM_DIGITS);
        // seg register sees the time from before this edge
        m_seg    = seg_expect(digit_at(m_cur, nxt_idx));
        m_idx    = nxt_idx;
        m_cur    = nxt_cur;
        m_finish = nxt_fin;
        m_tick   = (cyc % tb_tick_div == 0);
    endtask

    task automatic check_outputs();
        disp_word_t exp_word;
        logic [5:0] exp_sel;
        exp_word = word_of(m_cur);
        exp_sel  = 6'b000001 << m_idx;
        if (display_word !== exp_word) begin
            $display("[FAIL] display_word got %h exp %h cycle %0d", display_word, exp_word, cyc);
            errors++;
        end
        if (finish !== m_finish) begin
            $display("[FAIL] finish got %h exp %h cycle %0d", finish, m_finish, cyc);
            errors++;
        end
        if (digit_sel !== exp_sel) begin
            $display("[FAIL] digit_sel got %h exp %h cycle %0d", digit_sel, exp_sel, cyc);
            errors++;
        end
        if (seg !== m_seg) begin
            $display("[FAIL] seg got %h exp %h cycle %0d", seg, m_seg, cyc);
            errors++;
        end
        if (!$onehot(digit_sel)) begin
            $display("digit_sel is not one-hot in cycle %0d", cyc);
            errors++;
        end
    endtask

    // one clock: update model, drive the next inputs, check at the falling edge
    task automatic step(input logic load_v, input logic go_v, input disp_word_t pin_v);
        @(posedge clk);
        model_step();
        load      <= load_v;
        go        <= go_v;
        preset_in <= pin_v;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic run_cycles(input int n, input logic go_v);
        repeat (n) step(1'b0, go_v, preset_in);
    endtask

    task automatic wait_finish();
        int n;
        n = 0;
        while (finish !== 1'b1 && n < finish_wait) begin
            step(1'b0, 1'b1, preset_in);
            n++;
        end
        if (finish !== 1'b1) begin
            $display("finish never rose within %0d cycles", finish_wait);
            errors++;
        end
    endtask

    task automatic expect_word(input disp_word_t exp);
        if (display_word !== exp) begin
            $display("[FAIL] display_word got %h exp %h cycle %0d", display_word, exp, cyc);
            errors++;
        end
    endtask

    task automatic random_sequence(input int idx);
        logic [31:0] r;
        disp_word_t  pin;
        logic        go_v;
        int          c;
        r = lcg_next();
        // even sequences use short presets so the count reaches zero
        pin = (idx % 2 == 0) ? {28'h00F00F0, r[27:24]} : r;
        step(1'b1, 1'b0, pin);
        go_v = 1'b0;
        for (c = 0; c < seq_cycles - 1; c++) begin
            r = lcg_next();
            if (c == 2 || r[31:27] == 5'd0) begin
                go_v = !go_v;
            end
            if (r[26:23] == 4'd0) begin
                pin = lcg_next();
                step(1'b1, go_v, pin);
            end else begin
                step(1'b0, go_v, preset_in);
            end
        end
        run_cycles(2, 1'b0);
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, errors: %0d", watchdog_cycles, errors);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        lcg_state = 32'd80;
        errors    = 0;
        cyc       = 0;
        m_tick    = 1'b0;
        m_preset  = '0;
        m_cur     = '0;
        m_finish  = 1'b0;
        m_idx     = 3'd0;
        m_seg     = seg_expect(4'd0);
        rst_n     = 1'b0;
        load      = 1'b0;
        go        = 1'b0;
        preset_in = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // illegal digits clamp, blank nibbles ignored
        step(1'b1, 1'b0, 32'hC738_B56E);
        step(1'b0, 1'b0, 32'h0);
        step(1'b0, 1'b0, 32'h0);
        expect_word(32'h97F5_9F59);
        run_cycles(4, 1'b0);

        // borrow from hr_1, then from hr_10
        step(1'b1, 1'b0, 32'h01F0_0F00);
        run_cycles(2, 1'b0);
        run_cycles(22, 1'b1);
        run_cycles(3, 1'b0);
        step(1'b1, 1'b0, 32'h10F0_0F00);
        run_cycles(2, 1'b0);
        run_cycles(22, 1'b1);
        run_cycles(3, 1'b0);

        // countdown to zero and finish
        step(1'b1, 1'b0, 32'h00F0_0F03);
        run_cycles(2, 1'b0);
        step(1'b0, 1'b1, preset_in);
        wait_finish();
        run_cycles(8, 1'b1);
        run_cycles(3, 1'b0);
        if (finish !== 1'b0) begin
            $display("[FAIL] finish got %h exp 0 after go fell", finish);
            errors++;
        end
        expect_word(32'h00F0_0F03);

        // load while running only shows after go drops
        step(1'b1, 1'b0, 32'h00F0_1F00);
        run_cycles(2, 1'b0);
        run_cycles(12, 1'b1);
        step(1'b1, 1'b1, 32'h00F0_0F4A);
        run_cycles(10, 1'b1);
        run_cycles(3, 1'b0);
        expect_word(32'h00F0_0F49);

        for (int s = 0; s < num_seqs; s++) begin
            random_sequence(s);
        end

        $display("checks done after %0d cycles, errors: %0d", cyc, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tick_gen.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module tick_gen #(
    parameter int unsigned tick_div = `TIMER_TICK_DIV
) (
    input  logic clk,
    input  logic rst_n,
    output logic sec_tick
);

    // a divider of 1 still needs a one-bit counter
    localparam int unsigned cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == cnt_w'(tick_div - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // strobe is registered, lands in the cycle after the wrap
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sec_tick <= 1'b0;
        end else begin
            sec_tick <= wrap;
        end
    end

    generate
        if (tick_div > 1) begin : g_tick_chk
            // strobe never lasts more than one cycle
            a_single_cycle: assert property (
                @(posedge clk) disable iff (!rst_n)
                sec_tick |=> !sec_tick
            ) else $error("sec_tick high in two consecutive cycles");
        end
    endgenerate

endmodule

// File: timer_defs.svh
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// clk cycles per one-second strobe, 50 MHz board clock
`define TIMER_TICK_DIV 50000000

// clk cycles each digit stays selected during the scan
`define TIMER_SCAN_DIV 4

// digits on the seven-segment display, hh mm ss
`define TIMER_NUM_DIGITS 6

// separator nibble between the fields of the display word
`define TIMER_BLANK_NIBBLE 4'hf

`endif

// File: timer_pkg.sv
package timer_pkg;

    // one BCD digit
    typedef logic [3:0] bcd_digit_t;

    // hh:mm:ss as six BCD digits, hours in the top bits
    typedef struct packed {
        bcd_digit_t hr_10;
        bcd_digit_t hr_1;
        bcd_digit_t min_10;
        bcd_digit_t min_1;
        bcd_digit_t sec_10;
        bcd_digit_t sec_1;
    } hms_time_t;

    // display word, msb first
    // hr_10 hr_1 blank min_10 min_1 blank sec_10 sec_1
    typedef logic [31:0] disp_word_t;

    // countdown core FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } core_state_t;

endpackage

// File: verilog.f
+incdir+.
timer_pkg.sv
tick_gen.sv
preset_latch.sv
countdown_core.sv
display_scan.sv
countdown_timer.sv
tb_countdown_timer.sv
